// ==== include/mf_consts.svh ====
`ifndef MF_CONSTS_SVH
`define MF_CONSTS_SVH

// Grayscale pixel
`define MF_PIX_W    8

// Width, height, row and column values
`define MF_DIM_W    7

// Pixel address into either image memory
`define MF_ADDR_W   12

`define MF_MAX_DIM  64

// Window slots, also the number of sorter passes
`define MF_TAPS     9

// Host data bus
`define MF_WORD_W   32

`endif

// ==== design/mf_bus_pkg.sv ====
`include "mf_consts.svh"

package mf_bus_pkg;

    // On read, MODE_START returns the done status
    typedef enum logic [1:0] {
        MODE_PIXEL  = 2'd0,
        MODE_START  = 2'd1,
        MODE_WIDTH  = 2'd2,
        MODE_HEIGHT = 2'd3
    } mf_mode_e;

    typedef struct packed {
        mf_mode_e               mode;
        logic [`MF_ADDR_W-1:0]  offset;   // Pixel index, row * width + col
    } mf_host_addr_s;

    typedef struct packed {
        logic [`MF_WORD_W-`MF_PIX_W-1:0]  pad;
        logic [`MF_PIX_W-1:0]             pixel;
    } mf_pix_view_s;

    // Bit 0 of dim is start on write, done on read
    typedef struct packed {
        logic [`MF_WORD_W-`MF_DIM_W-1:0]  pad;
        logic [`MF_DIM_W-1:0]             dim;
    } mf_ctrl_view_s;

    typedef union packed {
        mf_pix_view_s   pix;
        mf_ctrl_view_s  ctrl;
    } mf_host_word_u;

endpackage

// ==== design/mf_core_pkg.sv ====
`include "mf_consts.svh"

package mf_core_pkg;

    typedef logic [`MF_PIX_W-1:0] mf_pixel_t;

    // Slot k covers row offset k/3-1, column offset k%3-1
    typedef mf_pixel_t [`MF_TAPS-1:0] mf_window_t;

    typedef struct packed {
        logic [`MF_DIM_W-1:0]   row;
        logic [`MF_DIM_W-1:0]   col;
        logic [`MF_ADDR_W-1:0]  row_base;   // row * width
    } mf_pos_s;

endpackage

// ==== design/mf_pixel_ram.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_pixel_ram (
    input  logic                    CLK,
    input  logic                    a_en_i,
    input  logic                    a_we_i,
    input  logic [`MF_ADDR_W-1:0]   a_addr_i,
    input  mf_core_pkg::mf_pixel_t  a_din_i,
    output mf_core_pkg::mf_pixel_t  a_dout_o,
    input  logic                    b_en_i,
    input  logic                    b_we_i,
    input  logic [`MF_ADDR_W-1:0]   b_addr_i,
    input  mf_core_pkg::mf_pixel_t  b_din_i,
    output mf_core_pkg::mf_pixel_t  b_dout_o
);

    localparam int DEPTH = `MF_MAX_DIM * `MF_MAX_DIM;

    mf_core_pkg::mf_pixel_t mem [DEPTH];

    always_ff @(posedge CLK) begin
        if (a_en_i) begin
            if (a_we_i) begin
                mem[a_addr_i] <= a_din_i;
            end
            a_dout_o <= mem[a_addr_i];   // Registered read
        end
        if (b_en_i) begin
            if (b_we_i) begin
                mem[b_addr_i] <= b_din_i;
            end
            b_dout_o <= mem[b_addr_i];
        end
    end

endmodule

// ==== design/mf_host_regs.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_host_regs (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        en_i,
    input  logic                        we_i,
    input  mf_bus_pkg::mf_host_addr_s   addr_i,
    input  mf_bus_pkg::mf_host_word_u   din_i,
    input  logic                        busy_i,
    input  logic                        done_i,
    input  mf_core_pkg::mf_pixel_t      pix_i,
    output logic                        in_we_o,
    output logic                        out_rd_o,
    output logic [`MF_ADDR_W-1:0]       mem_addr_o,
    output mf_core_pkg::mf_pixel_t      mem_din_o,
    output logic                        start_o,
    output logic [`MF_DIM_W-1:0]        width_o,
    output logic [`MF_DIM_W-1:0]        height_o,
    output mf_bus_pkg::mf_host_word_u   dout_o
);

    logic                   start_q;
    logic [`MF_DIM_W-1:0]   width_q;
    logic [`MF_DIM_W-1:0]   height_q;
    mf_bus_pkg::mf_mode_e   rd_mode_q;   // Lines up with the memory output
    logic                   pix_access;

    assign pix_access = en_i && (addr_i.mode == mf_bus_pkg::MODE_PIXEL);
    assign in_we_o    = pix_access && we_i && !busy_i;   // Image is frozen while busy
    assign out_rd_o   = pix_access && !we_i;
    assign mem_addr_o = addr_i.offset;
    assign mem_din_o  = din_i.pix.pixel;

    assign start_o  = start_q;
    assign width_o  = width_q;
    assign height_o = height_q;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start_q   <= 1'b0;
            width_q   <= '0;
            height_q  <= '0;
            rd_mode_q <= mf_bus_pkg::MODE_PIXEL;
        end else begin
            if (en_i && we_i) begin
                case (addr_i.mode)
                    mf_bus_pkg::MODE_START:  start_q  <= din_i.ctrl.dim[0];
                    mf_bus_pkg::MODE_WIDTH:  width_q  <= din_i.ctrl.dim;
                    mf_bus_pkg::MODE_HEIGHT: height_q <= din_i.ctrl.dim;
                    default: ;
                endcase
            end
            if (en_i && !we_i) begin
                rd_mode_q <= addr_i.mode;
            end
        end
    end

    always_comb begin
        dout_o = '0;
        case (rd_mode_q)
            mf_bus_pkg::MODE_START:  dout_o.ctrl.dim[0] = done_i;
            mf_bus_pkg::MODE_WIDTH:  dout_o.ctrl.dim = width_q;
            mf_bus_pkg::MODE_HEIGHT: dout_o.ctrl.dim = height_q;
            default: begin
                if (done_i) begin
                    dout_o.pix.pixel = pix_i;   // Result only valid once done
                end
            end
        endcase
    end

endmodule

// ==== design/mf_scan_ctrl.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_scan_ctrl (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    start_i,
    input  logic [`MF_DIM_W-1:0]    width_i,
    input  logic [`MF_DIM_W-1:0]    height_i,
    input  logic                    sort_valid_i,
    input  mf_core_pkg::mf_pixel_t  median_i,
    output mf_core_pkg::mf_pos_s    pos_o,
    output logic [3:0]              tap_o,
    output logic                    fetch_o,
    output logic                    out_we_o,
    output logic [`MF_ADDR_W-1:0]   out_addr_o,
    output mf_core_pkg::mf_pixel_t  out_din_o,
    output logic                    busy_o,
    output logic                    done_o
);

    typedef enum logic [1:0] {IDLE, EXEC, DONE} state_e;

    state_e                 state_q;
    mf_core_pkg::mf_pos_s   pos_q;
    logic [3:0]             tap_q;
    logic                   fetch_q;
    logic                   last_col;
    logic                   last_row;

    assign last_col = pos_q.col == width_i - 1'b1;
    assign last_row = pos_q.row == height_i - 1'b1;

    // Median goes out in the valid cycle itself
    assign out_we_o   = (state_q == EXEC) && sort_valid_i;
    assign out_addr_o = pos_q.row_base + `MF_ADDR_W'(pos_q.col);
    assign out_din_o  = median_i;

    assign pos_o   = pos_q;
    assign tap_o   = tap_q;
    assign fetch_o = fetch_q;
    assign busy_o  = state_q == EXEC;
    assign done_o  = state_q == DONE;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q <= IDLE;
            pos_q   <= '0;
            tap_q   <= '0;
            fetch_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= EXEC;
                        pos_q   <= '0;
                        tap_q   <= '0;
                        fetch_q <= 1'b1;
                    end
                end
                EXEC: begin
                    if (fetch_q) begin
                        if (tap_q == 4'(`MF_TAPS-1)) begin
                            fetch_q <= 1'b0;   // Wait for the sorter
                            tap_q   <= '0;
                        end else begin
                            tap_q <= tap_q + 1'b1;
                        end
                    end else if (sort_valid_i) begin
                        if (last_col && last_row) begin
                            state_q <= DONE;
                        end else begin
                            fetch_q <= 1'b1;
                            if (last_col) begin
                                pos_q.row      <= pos_q.row + 1'b1;
                                pos_q.col      <= '0;
                                pos_q.row_base <= pos_q.row_base + `MF_ADDR_W'(width_i);
                            end else begin
                                pos_q.col <= pos_q.col + 1'b1;
                            end
                        end
                    end
                end
                DONE: begin
                    if (!start_i) begin
                        state_q <= IDLE;   // Host acknowledged
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    a_tap_range: assert property (@(posedge CLK) disable iff (!RST) tap_o <= 4'(`MF_TAPS-1))
        else $error("tap index out of range");

endmodule

// ==== design/mf_window_fetch.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_window_fetch (
    input  logic                    CLK,
    input  logic                    RST,
    input  mf_core_pkg::mf_pos_s    pos_i,
    input  logic [3:0]              tap_i,
    input  logic                    fetch_i,
    input  logic [`MF_DIM_W-1:0]    width_i,
    input  logic [`MF_DIM_W-1:0]    height_i,
    output logic                    rd_en_o,
    output logic [`MF_ADDR_W-1:0]   rd_addr_o,
    input  mf_core_pkg::mf_pixel_t  rd_data_i,
    output mf_core_pkg::mf_window_t window_o,
    output logic                    full_o
);

    logic                       up;
    logic                       down;
    logic                       left;
    logic                       right;
    logic                       pad;
    logic [`MF_ADDR_W-1:0]      addr;
    logic                       land_q;
    logic [3:0]                 slot_q;
    logic                       pad_q;
    logic                       full_q;
    mf_core_pkg::mf_window_t    window_q;

    // Neighbour direction from the slot index
    always_comb begin
        up    = tap_i < 4'd3;
        down  = tap_i > 4'd5;
        left  = (tap_i == 4'd0) || (tap_i == 4'd3) || (tap_i == 4'd6);
        right = (tap_i == 4'd2) || (tap_i == 4'd5) || (tap_i == 4'd8);
        pad   = (up && pos_i.row == '0) || (down && pos_i.row == height_i - 1'b1) ||
                (left && pos_i.col == '0) || (right && pos_i.col == width_i - 1'b1);
        addr  = pos_i.row_base + `MF_ADDR_W'(pos_i.col);
        if (up) begin
            addr = addr - `MF_ADDR_W'(width_i);
        end
        if (down) begin
            addr = addr + `MF_ADDR_W'(width_i);
        end
        if (left) begin
            addr = addr - 1'b1;
        end
        if (right) begin
            addr = addr + 1'b1;
        end
    end

    assign rd_en_o   = fetch_i && !pad;   // No access for border taps
    assign rd_addr_o = addr;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            land_q <= 1'b0;
            slot_q <= '0;
            pad_q  <= 1'b0;
            full_q <= 1'b0;
        end else begin
            land_q <= fetch_i;
            slot_q <= tap_i;
            pad_q  <= pad;
            full_q <= land_q && (slot_q == 4'(`MF_TAPS-1));
        end
    end

    // Slot lands with the memory read data
    always_ff @(posedge CLK) begin
        if (land_q) begin
            window_q[slot_q] <= pad_q ? '0 : rd_data_i;
        end
    end

    assign window_o = window_q;
    assign full_o   = full_q;

endmodule

// ==== design/mf_median_sort.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_median_sort (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    start_i,
    input  mf_core_pkg::mf_window_t window_i,
    output mf_core_pkg::mf_pixel_t  median_o,
    output logic                    valid_o
);

    mf_core_pkg::mf_window_t    data_q;
    mf_core_pkg::mf_window_t    data_next;
    logic [3:0]                 pass_q;
    logic                       run_q;
    logic                       valid_q;

    // Even pass pairs (0,1)..(6,7), odd pass pairs (1,2)..(7,8)
    always_comb begin
        data_next = data_q;
        for (int i = 0; i < `MF_TAPS-1; i++) begin
            if (((i % 2) == 1) == pass_q[0] && data_q[i] > data_q[i+1]) begin
                data_next[i]   = data_q[i+1];
                data_next[i+1] = data_q[i];
            end
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            run_q   <= 1'b0;
            pass_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= run_q && (pass_q == 4'(`MF_TAPS-1));
            if (start_i) begin
                run_q  <= 1'b1;
                pass_q <= '0;
            end else if (run_q) begin
                pass_q <= pass_q + 1'b1;
                if (pass_q == 4'(`MF_TAPS-1)) begin
                    run_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start_i) begin
            data_q <= window_i;
        end else if (run_q) begin
            data_q <= data_next;
        end
    end

    assign median_o = data_q[(`MF_TAPS-1)/2];   // Middle of the sorted window
    assign valid_o  = valid_q;

    a_valid_after_start: assert property (@(posedge CLK) disable iff (!RST)
        valid_o |-> $past(start_i, `MF_TAPS+1))
        else $error("sort valid without a matching start");

endmodule

// ==== design/median_filter_unit.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module median_filter_unit (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        en_i,
    input  logic                        we_i,
    input  mf_bus_pkg::mf_host_addr_s   addr_i,
    input  mf_bus_pkg::mf_host_word_u   din_i,
    output mf_bus_pkg::mf_host_word_u   dout_o
);

    logic                       in_we;
    logic                       out_rd;
    logic [`MF_ADDR_W-1:0]      mem_addr;
    mf_core_pkg::mf_pixel_t     mem_din;
    mf_core_pkg::mf_pixel_t     out_pix;
    logic                       start;
    logic [`MF_DIM_W-1:0]       width;
    logic [`MF_DIM_W-1:0]       height;
    logic                       busy;
    logic                       done;
    mf_core_pkg::mf_pos_s       pos;
    logic [3:0]                 tap;
    logic                       fetch;
    logic                       out_we;
    logic [`MF_ADDR_W-1:0]      out_addr;
    mf_core_pkg::mf_pixel_t     out_din;
    logic                       rd_en;
    logic [`MF_ADDR_W-1:0]      rd_addr;
    mf_core_pkg::mf_pixel_t     rd_data;
    mf_core_pkg::mf_window_t    window;
    logic                       full;
    mf_core_pkg::mf_pixel_t     median;
    logic                       sort_valid;

    mf_host_regs i_host_regs (
        .CLK(CLK), .RST(RST), .en_i(en_i), .we_i(we_i), .addr_i(addr_i), .din_i(din_i),
        .busy_i(busy), .done_i(done), .pix_i(out_pix),
        .in_we_o(in_we), .out_rd_o(out_rd), .mem_addr_o(mem_addr), .mem_din_o(mem_din),
        .start_o(start), .width_o(width), .height_o(height), .dout_o(dout_o)
    );

    // Host writes port A, engine reads port B
    mf_pixel_ram i_in_ram (
        .CLK(CLK),
        .a_en_i(in_we), .a_we_i(in_we), .a_addr_i(mem_addr), .a_din_i(mem_din), .a_dout_o(),
        .b_en_i(rd_en), .b_we_i(1'b0), .b_addr_i(rd_addr), .b_din_i('0), .b_dout_o(rd_data)
    );

    // Host reads port A, engine writes port B
    mf_pixel_ram i_out_ram (
        .CLK(CLK),
        .a_en_i(out_rd), .a_we_i(1'b0), .a_addr_i(mem_addr), .a_din_i('0), .a_dout_o(out_pix),
        .b_en_i(out_we), .b_we_i(out_we), .b_addr_i(out_addr), .b_din_i(out_din), .b_dout_o()
    );

    mf_scan_ctrl i_scan_ctrl (
        .CLK(CLK), .RST(RST), .start_i(start), .width_i(width), .height_i(height),
        .sort_valid_i(sort_valid), .median_i(median),
        .pos_o(pos), .tap_o(tap), .fetch_o(fetch), .out_we_o(out_we), .out_addr_o(out_addr),
        .out_din_o(out_din), .busy_o(busy), .done_o(done)
    );

    mf_window_fetch i_window_fetch (
        .CLK(CLK), .RST(RST), .pos_i(pos), .tap_i(tap), .fetch_i(fetch),
        .width_i(width), .height_i(height), .rd_en_o(rd_en), .rd_addr_o(rd_addr),
        .rd_data_i(rd_data), .window_o(window), .full_o(full)
    );

    mf_median_sort i_median_sort (
        .CLK(CLK), .RST(RST), .start_i(full), .window_i(window),
        .median_o(median), .valid_o(sort_valid)
    );

endmodule

// ==== verif/tb_median_filter.sv ====
`timescale 1ns/1ps
`include "mf_consts.svh"

module tb_median_filter;

    localparam int CLK_PERIOD = 4;
    localparam int RUN_PIXELS = 1 + 8*6 + 6*5 + 2*4*4;   // Pixels filtered over all runs
    localparam int RUNS = 5;
    localparam int WATCHDOG_CYCLES = 30*RUN_PIXELS + 600*RUNS;

    logic                       CLK;
    logic                       RST;
    logic                       en;
    logic                       we;
    mf_bus_pkg::mf_host_addr_s  addr;
    mf_bus_pkg::mf_host_word_u  din;
    mf_bus_pkg::mf_host_word_u  dout;

    mf_core_pkg::mf_pixel_t img [`MF_MAX_DIM*`MF_MAX_DIM];   // Image as the host loaded it
    int checks;
    int errors;

    median_filter_unit i_dut (
        .CLK(CLK), .RST(RST), .en_i(en), .we_i(we), .addr_i(addr), .din_i(din), .dout_o(dout)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD/2) CLK = ~CLK;
    end

    task automatic check_pixel(input string name, input mf_core_pkg::mf_pixel_t exp,
                               input mf_core_pkg::mf_pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input mf_bus_pkg::mf_host_word_u exp,
                              input mf_bus_pkg::mf_host_word_u act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic host_write(input mf_bus_pkg::mf_mode_e mode, input int offset,
                              input mf_bus_pkg::mf_host_word_u word);
        mf_bus_pkg::mf_host_addr_s a;
        a.mode   = mode;
        a.offset = `MF_ADDR_W'(offset);
        @(posedge CLK);
        en   <= 1'b1;
        we   <= 1'b1;
        addr <= a;
        din  <= word;
        @(posedge CLK);
        en <= 1'b0;
        we <= 1'b0;
    endtask

    // Answer word is stable from the edge after the request
    task automatic host_read(input mf_bus_pkg::mf_mode_e mode, input int offset,
                             output mf_bus_pkg::mf_host_word_u word);
        mf_bus_pkg::mf_host_addr_s a;
        a.mode   = mode;
        a.offset = `MF_ADDR_W'(offset);
        @(posedge CLK);
        en   <= 1'b1;
        we   <= 1'b0;
        addr <= a;
        @(posedge CLK);
        en <= 1'b0;
        @(negedge CLK);
        word = dout;
    endtask

    task automatic write_ctrl(input mf_bus_pkg::mf_mode_e mode, input int value);
        mf_bus_pkg::mf_host_word_u word;
        word = '0;
        word.ctrl.dim = `MF_DIM_W'(value);
        host_write(mode, 0, word);
    endtask

    task automatic write_pixel(input int offset, input mf_core_pkg::mf_pixel_t pix);
        mf_bus_pkg::mf_host_word_u word;
        word = '0;
        word.pix.pixel = pix;
        host_write(mf_bus_pkg::MODE_PIXEL, offset, word);
    endtask

    task automatic check_status(input logic exp_done, input string name);
        mf_bus_pkg::mf_host_word_u word;
        mf_bus_pkg::mf_host_word_u exp;
        exp = '0;
        exp.ctrl.dim[0] = exp_done;
        host_read(mf_bus_pkg::MODE_START, 0, word);
        check_word(name, exp, word);
    endtask

    task automatic check_dims(input int w, input int h);
        mf_bus_pkg::mf_host_word_u word;
        mf_bus_pkg::mf_host_word_u exp;
        exp = '0;
        exp.ctrl.dim = `MF_DIM_W'(w);
        host_read(mf_bus_pkg::MODE_WIDTH, 0, word);
        check_word("width", exp, word);
        exp.ctrl.dim = `MF_DIM_W'(h);
        host_read(mf_bus_pkg::MODE_HEIGHT, 0, word);
        check_word("height", exp, word);
    endtask

    task automatic load_image(input int w, input int h);
        write_ctrl(mf_bus_pkg::MODE_WIDTH, w);
        write_ctrl(mf_bus_pkg::MODE_HEIGHT, h);
        for (int i = 0; i < w*h; i++) begin
            write_pixel(i, img[i]);
        end
    endtask

    task automatic wait_done(input int w, input int h);
        mf_bus_pkg::mf_host_word_u word;
        int polls;
        int limit;
        limit = 30*w*h + 100;
        polls = 0;
        word  = '0;
        while (word.ctrl.dim[0] !== 1'b1 && polls < limit) begin
            host_read(mf_bus_pkg::MODE_START, 0, word);
            polls++;
        end
        if (word.ctrl.dim[0] !== 1'b1) begin
            errors++;
            $display("Engine never reported done after %0d status polls", polls);
        end
    endtask

    task automatic stop_engine();
        write_ctrl(mf_bus_pkg::MODE_START, 0);
        check_status(1'b0, "status after start cleared");
    endtask

    // Zero-padded 3x3 neighbourhood, fully sorted, middle value
    function automatic mf_core_pkg::mf_pixel_t ref_median(input int row, input int col,
                                                          input int w, input int h);
        mf_core_pkg::mf_pixel_t vals [9];
        mf_core_pkg::mf_pixel_t tmp;
        int n;
        int r;
        int c;
        n = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                r = row + dr;
                c = col + dc;
                vals[n] = (r < 0 || r >= h || c < 0 || c >= w) ? '0 : img[r*w + c];
                n++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8 - i; j++) begin
                if (vals[j] > vals[j+1]) begin
                    tmp       = vals[j];
                    vals[j]   = vals[j+1];
                    vals[j+1] = tmp;
                end
            end
        end
        return vals[4];
    endfunction

    task automatic check_image(input int w, input int h);
        mf_bus_pkg::mf_host_word_u word;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                host_read(mf_bus_pkg::MODE_PIXEL, r*w + c, word);
                check_pixel($sformatf("median[%0d][%0d]", r, c), ref_median(r, c, w, h),
                            word.pix.pixel);
            end
        end
    endtask

    task automatic test_reset_state();
        mf_bus_pkg::mf_host_word_u word;
        check_status(1'b0, "status after reset");
        host_read(mf_bus_pkg::MODE_PIXEL, 0, word);
        check_word("pixel after reset", '0, word);
    endtask

    // Eight of nine slots are border zeros
    task automatic test_single_pixel();
        mf_bus_pkg::mf_host_word_u word;
        img[0] = mf_core_pkg::mf_pixel_t'($urandom_range(255, 1));
        load_image(1, 1);
        write_ctrl(mf_bus_pkg::MODE_START, 1);
        wait_done(1, 1);
        check_dims(1, 1);
        host_read(mf_bus_pkg::MODE_PIXEL, 0, word);
        check_pixel("median[0][0]", 8'd0, word.pix.pixel);
        stop_engine();
    endtask

    task automatic test_random_image();
        for (int i = 0; i < 8*6; i++) begin
            img[i] = mf_core_pkg::mf_pixel_t'($urandom);
        end
        load_image(8, 6);
        write_ctrl(mf_bus_pkg::MODE_START, 1);
        wait_done(8, 6);
        check_dims(8, 6);
        check_image(8, 6);
        stop_engine();
    endtask

    task automatic test_constant_image();
        mf_bus_pkg::mf_host_word_u word;
        logic corner;
        for (int i = 0; i < 6*5; i++) begin
            img[i] = 8'd200;
        end
        load_image(6, 5);
        write_ctrl(mf_bus_pkg::MODE_START, 1);
        wait_done(6, 5);
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 6; c++) begin
                corner = (r == 0 || r == 4) && (c == 0 || c == 5);   // Only four of nine inside
                host_read(mf_bus_pkg::MODE_PIXEL, r*6 + c, word);
                check_pixel($sformatf("median[%0d][%0d]", r, c), corner ? 8'd0 : 8'd200,
                            word.pix.pixel);
            end
        end
        stop_engine();
    endtask

    task automatic test_done_hold();
        for (int i = 0; i < 4*4; i++) begin
            img[i] = mf_core_pkg::mf_pixel_t'($urandom);
        end
        load_image(4, 4);
        write_ctrl(mf_bus_pkg::MODE_START, 1);
        for (int i = 0; i < 4*4; i++) begin
            write_pixel(i, ~img[i]);   // Dropped while the engine is busy
        end
        wait_done(4, 4);
        repeat (40) @(posedge CLK);
        check_status(1'b1, "status held while start high");
        check_image(4, 4);
        stop_engine();
        write_ctrl(mf_bus_pkg::MODE_START, 1);
        wait_done(4, 4);
        check_image(4, 4);
        stop_engine();
    endtask

    initial begin
        checks   = 0;
        errors   = 0;
        void'($urandom(32'hf32e285f));
        RST  = 1'b0;
        en   = 1'b0;
        we   = 1'b0;
        addr = '0;
        din  = '0;
        repeat (2) @(posedge CLK);
        RST <= 1'b1;
        test_reset_state();
        test_single_pixel();
        test_random_image();
        test_constant_image();
        test_done_hold();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/mf_bus_pkg.sv
design/mf_core_pkg.sv
design/mf_pixel_ram.sv
design/mf_host_regs.sv
design/mf_scan_ctrl.sv
design/mf_window_fetch.sv
design/mf_median_sort.sv
design/median_filter_unit.sv
verif/tb_median_filter.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_median_filter \
        -o tb_median_filter_sim \
    && ./obj_dir/tb_median_filter_sim | tee /dev/stderr | grep -q "Test passed" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
